//--- hdl/lce_cmd_pkg.sv
// LCE command package.
// Message types, field widths, sizes and the wormhole packet-length helper
// shared by the coherence network transmit path.
package lce_cmd_pkg;

  // Field widths of the id and router header.
  localparam int lce_id_width_c  = 4;
  localparam int cord_width_c    = 8;
  localparam int len_width_c     = 5;
  localparam int cid_width_c     = 2;
  localparam int block_width_c   = 512;  // One cache block.
  localparam int wh_hdr_width_c  = 67;   // Router plus message header, unpadded.

  // Command types. Only data and uc_data carry a block.
  typedef enum logic [3:0] {
    e_cmd_sync      = 4'd0,
    e_cmd_set_clear = 4'd1,
    e_cmd_inv       = 4'd2,
    e_cmd_st        = 4'd3,
    e_cmd_wb        = 4'd4,
    e_cmd_st_wb     = 4'd5,
    e_cmd_tr        = 4'd6,
    e_cmd_st_tr     = 4'd7,
    e_cmd_st_tr_wb  = 4'd8,
    e_cmd_data      = 4'd9,
    e_cmd_uc_data   = 4'd10
  } lce_msg_type_e;

  // Data size, log2 of the byte count.
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5,
    e_size_64 = 3'd6
  } lce_msg_size_e;

  typedef struct packed {
    lce_msg_type_e             msg_type;  // Top bits.
    lce_msg_size_e             size;
    logic [lce_id_width_c-1:0] dst_id;
    logic [lce_id_width_c-1:0] src_id;
    logic [2:0]                way_id;
    logic [33:0]               addr;      // Block address.
  } lce_cmd_header_s;  // 52 bits.

  typedef struct packed {
    lce_cmd_header_s           header;
    logic [block_width_c-1:0]  data;
  } lce_cmd_msg_s;

  // Cord sits in the lowest bits, as routers read it first.
  typedef struct packed {
    logic [cid_width_c-1:0]    cid;
    logic [len_width_c-1:0]    len;
    logic [cord_width_c-1:0]   cord;
  } wh_rtr_hdr_s;  // 15 bits.

  typedef struct packed {
    lce_cmd_header_s           msg_hdr;
    wh_rtr_hdr_s               rtr_hdr;
  } lce_cmd_wh_header_s;  // 67 bits.

  // Packet length in flits minus one.
  function automatic int wh_len_f(int flit_width, int data_bytes);
    return (wh_hdr_width_c + 8 * data_bytes + flit_width - 1) / flit_width - 1;
  endfunction

endpackage

//--- hdl/lce_cmd_ingress_fifo.sv
// Ingress queue for LCE commands.
// Circular buffer with no back-pressure; a write into a full queue is
// dropped and reported one cycle later on overflow_o.
`timescale 1ns/1ps

module lce_cmd_ingress_fifo #(
  parameter int  depth_p   = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wr_v_i,      // Write strobe.
  input  payload_t wr_data_i,
  input  logic     pop_i,       // Consumer takes the head.
  output payload_t head_o,
  output logic     head_v_o,
  output logic     overflow_o   // One pulse per dropped write.
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem_q [depth_p];  // Storage, no reset.
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    full;
  logic                    wr_en;
  logic                    rd_en;
  logic                    overflow_q;

  // Wrap explicitly so any depth works.
  function automatic logic [ptr_width_lp-1:0] next_ptr(logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == cnt_width_lp'(depth_p));
  assign wr_en = wr_v_i & ~full;    // Full blocks even with a pop this cycle.
  assign rd_en = pop_i & head_v_o;

  always_ff @(posedge clk_i) begin
    if (wr_en) mem_q[wr_ptr_q] <= wr_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_en) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (rd_en) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (wr_en && !rd_en) count_q <= count_q + 1'b1;
      else if (!wr_en && rd_en) count_q <= count_q - 1'b1;
      overflow_q <= wr_v_i & full;  // Dropped command.
    end
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign head_v_o   = (count_q != '0);
  assign overflow_o = overflow_q;

endmodule

//--- hdl/lce_id_to_cord.sv
// LCE id to router coordinate map.
// Single destination row: the id pair shares a column, bit 0 picks the cid.
`timescale 1ns/1ps

module lce_id_to_cord
  import lce_cmd_pkg::*;
#(
  parameter int lce_y_cord_p = 1
) (
  input  logic [lce_id_width_c-1:0] lce_id_i,
  output logic [cord_width_c-1:0]   cord_o,
  output logic [cid_width_c-1:0]    cid_o
);

  localparam int half_lp = cord_width_c / 2;  // Nibble per axis.

  logic [half_lp-1:0] x_cord;
  logic [half_lp-1:0] y_cord;

  assign x_cord = half_lp'(lce_id_i[lce_id_width_c-1:1]);  // Two LCEs per column.
  assign y_cord = half_lp'(lce_y_cord_p);                    // Fixed row.

  assign cord_o = {y_cord, x_cord};
  assign cid_o  = cid_width_c'(lce_id_i[0]);                 // Concentrator port.

endmodule

//--- hdl/lce_cmd_wh_encode.sv
// Wormhole header encoder for LCE commands.
// Header = {pad, msg header, cid, len, cord}; len follows type and size.
`timescale 1ns/1ps

module lce_cmd_wh_encode
  import lce_cmd_pkg::*;
#(
  parameter int flit_width_p = 32,
  parameter int lce_y_cord_p = 1
) (
  input  lce_cmd_header_s    cmd_header_i,
  output lce_cmd_wh_header_s wh_header_o
);

  // Flit counts minus one, per payload size.
  localparam int len_cmd_lp = wh_len_f(flit_width_p, 0);
  localparam int len_1_lp   = wh_len_f(flit_width_p, 1);
  localparam int len_2_lp   = wh_len_f(flit_width_p, 2);
  localparam int len_4_lp   = wh_len_f(flit_width_p, 4);
  localparam int len_8_lp   = wh_len_f(flit_width_p, 8);
  localparam int len_16_lp  = wh_len_f(flit_width_p, 16);
  localparam int len_32_lp  = wh_len_f(flit_width_p, 32);
  localparam int len_64_lp  = wh_len_f(flit_width_p, 64);

  logic [cord_width_c-1:0] cord;
  logic [cid_width_c-1:0]  cid;

  lce_id_to_cord #(
    .lce_y_cord_p(lce_y_cord_p)
  ) lce_id_to_cord_i (
    .lce_id_i(cmd_header_i.dst_id),
    .cord_o  (cord),
    .cid_o   (cid)
  );

  always_comb begin
    wh_header_o              = '0;
    wh_header_o.msg_hdr      = cmd_header_i;  // Carried unchanged.
    wh_header_o.rtr_hdr.cid  = cid;
    wh_header_o.rtr_hdr.cord = cord;
    case (cmd_header_i.msg_type)
      e_cmd_sync, e_cmd_set_clear, e_cmd_inv,
      e_cmd_st, e_cmd_wb, e_cmd_st_wb,
      e_cmd_tr, e_cmd_st_tr, e_cmd_st_tr_wb:
        wh_header_o.rtr_hdr.len = len_width_c'(len_cmd_lp);  // Header only.
      e_cmd_data, e_cmd_uc_data: begin
        case (cmd_header_i.size)
          e_size_1:  wh_header_o.rtr_hdr.len = len_width_c'(len_1_lp);
          e_size_2:  wh_header_o.rtr_hdr.len = len_width_c'(len_2_lp);
          e_size_4:  wh_header_o.rtr_hdr.len = len_width_c'(len_4_lp);
          e_size_8:  wh_header_o.rtr_hdr.len = len_width_c'(len_8_lp);
          e_size_16: wh_header_o.rtr_hdr.len = len_width_c'(len_16_lp);
          e_size_32: wh_header_o.rtr_hdr.len = len_width_c'(len_32_lp);
          e_size_64: wh_header_o.rtr_hdr.len = len_width_c'(len_64_lp);
          default:   wh_header_o.rtr_hdr.len = '0;  // Unused size code.
        endcase
      end
      default: wh_header_o.rtr_hdr.len = '0;       // Unknown type, one flit.
    endcase
  end

endmodule

//--- hdl/wh_flit_serializer.sv
// Wormhole flit serializer.
// Loads header and block into a shift register and sends len + 1 flits,
// lowest bits first, one per cycle.
`timescale 1ns/1ps

module wh_flit_serializer
  import lce_cmd_pkg::*;
#(
  parameter int flit_width_p = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     pkt_v_i,      // Packet waiting at queue head.
  input  lce_cmd_wh_header_s       wh_header_i,
  input  logic [block_width_c-1:0] data_i,
  output logic                     pop_o,        // Taken this cycle.
  output logic                     flit_v_o,
  output logic [flit_width_p-1:0]  flit_o,
  output logic                     last_o
);

  // Body rounded up to whole flits; padding past the block is zero.
  localparam int body_width_lp = wh_hdr_width_c + block_width_c;
  localparam int max_flits_lp  = (body_width_lp + flit_width_p - 1) / flit_width_p;
  localparam int sr_width_lp   = max_flits_lp * flit_width_p;

  logic [sr_width_lp-1:0] sr_q;       // Payload, no reset.
  logic [len_width_c-1:0] cnt_q;      // Flits left after the current one.
  logic                   active_q;
  logic                   ready;
  logic                   load;

  // Free when idle or on the final flit, so packets run back to back.
  assign ready = ~active_q | last_o;
  assign load  = pkt_v_i & ready;
  assign pop_o = load;

  always_ff @(posedge clk_i) begin
    if (load) begin
      sr_q <= sr_width_lp'({data_i, wh_header_i});  // Header in the low bits.
    end else if (active_q) begin
      sr_q <= sr_q >> flit_width_p;                 // Next flit down.
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (load) begin
      active_q <= 1'b1;
      cnt_q    <= wh_header_i.rtr_hdr.len;
    end else if (active_q) begin
      if (cnt_q == '0) active_q <= 1'b0;  // Packet done.
      else cnt_q <= cnt_q - 1'b1;
    end
  end

  assign flit_v_o = active_q;
  assign flit_o   = sr_q[flit_width_p-1:0];
  assign last_o   = active_q & (cnt_q == '0);

endmodule

//--- hdl/lce_cmd_wh_tx.sv
// LCE command wormhole transmit endpoint.
// Queues commands, encodes the wormhole header and serializes flits.
`timescale 1ns/1ps

module lce_cmd_wh_tx
  import lce_cmd_pkg::*;
#(
  parameter int flit_width_p = 32,
  parameter int fifo_depth_p = 4,
  parameter int lce_y_cord_p = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_v_i,     // One-cycle command strobe.
  input  lce_cmd_msg_s            cmd_i,
  output logic                    flit_v_o,
  output logic [flit_width_p-1:0] flit_o,
  output logic                    last_o,      // Final flit of a packet.
  output logic                    overflow_o   // Command dropped.
);

  lce_cmd_msg_s       head;
  logic               head_v;
  logic               pop;
  lce_cmd_wh_header_s wh_header;

  lce_cmd_ingress_fifo #(
    .depth_p  (fifo_depth_p),
    .payload_t(lce_cmd_msg_s)
  ) lce_cmd_ingress_fifo_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_v_i    (cmd_v_i),
    .wr_data_i (cmd_i),
    .pop_i     (pop),
    .head_o    (head),
    .head_v_o  (head_v),
    .overflow_o(overflow_o)
  );

  // Header built straight from the queue head.
  lce_cmd_wh_encode #(
    .flit_width_p(flit_width_p),
    .lce_y_cord_p(lce_y_cord_p)
  ) lce_cmd_wh_encode_i (
    .cmd_header_i(head.header),
    .wh_header_o (wh_header)
  );

  wh_flit_serializer #(
    .flit_width_p(flit_width_p)
  ) wh_flit_serializer_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pkt_v_i    (head_v),
    .wh_header_i(wh_header),
    .data_i     (head.data),
    .pop_o      (pop),
    .flit_v_o   (flit_v_o),
    .flit_o     (flit_o),
    .last_o     (last_o)
  );

endmodule

//--- sim/wh_flit_checker.sv
// Flit checker for the LCE command wormhole transmit endpoint.
// Tracks the command queue from the strobe timing, builds the expected flits
// and compares them cycle by cycle with the DUT outputs.
`timescale 1ns/1ps

module wh_flit_checker
  import lce_cmd_pkg::*;
#(
  parameter int flit_width_p = 32,
  parameter int fifo_depth_p = 4,
  parameter int lce_y_cord_p = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_v_i,
  input  lce_cmd_msg_s            cmd_i,
  input  logic                    flit_v_i,
  input  logic [flit_width_p-1:0] flit_i,
  input  logic                    last_i,
  input  logic                    overflow_i,
  input  logic [3:0]              test_id_i,
  input  logic                    test_end_i,   // Prints the test line.
  input  logic                    run_end_i,    // Prints the closing counts.
  output logic                    idle_o,       // Nothing queued or in flight.
  output int                      fail_cnt_o,
  output int                      pass_cnt_o
);

  lce_cmd_msg_s            pend_q [$];     // Accepted, not yet loaded.
  logic [flit_width_p-1:0] flits_q [$];    // Flits left of the current packet.
  logic                    ovf_exp_q = 1'b0;
  logic                    full;
  int flit_idx = 0;
  int pkt_cnt = 0;
  int ovf_cnt = 0;
  int test_fail = 0;
  int tests_run = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  // Length from type and size, flits minus one.
  function automatic int exp_len(lce_cmd_header_s h);
    int bytes;
    if (h.msg_type > e_cmd_uc_data) return 0;  // Unknown type.
    bytes = (h.msg_type inside {e_cmd_data, e_cmd_uc_data}) ? (1 << h.size) : 0;
    return (wh_hdr_width_c + 8 * bytes + flit_width_p - 1) / flit_width_p - 1;
  endfunction

  task automatic load_packet(lce_cmd_msg_s c);
    logic [4:0] len;
    logic [7:0] cord;
    logic [1:0] cid;
    logic [wh_hdr_width_c+block_width_c-1:0] body;
    len  = 5'(exp_len(c.header));
    cord = {4'(lce_y_cord_p), 1'b0, c.header.dst_id[3:1]};  // Row, then column.
    cid  = {1'b0, c.header.dst_id[0]};
    body = {c.data, c.header, cid, len, cord};              // Header in the low bits.
    for (int k = 0; k <= int'(len); k++) begin
      flits_q.push_back(flit_width_p'(body >> (k * flit_width_p)));
    end
  endtask

  task automatic compare(string name, logic [flit_width_p-1:0] got,
                         logic [flit_width_p-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %0h expected %0h (test %0d)", name, got, exp, test_id_i);
      fail_cnt++;
      test_fail++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Sampled mid-cycle, where inputs and outputs are settled.
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      pend_q.delete();
      flits_q.delete();
      ovf_exp_q = 1'b0;
      flit_idx  = 0;
    end else begin
      if (flits_q.size() != 0) begin
        if (!flit_v_i) begin
          $display("Gap inside packet: flit_v_o low at flit %0d (test %0d)", flit_idx, test_id_i);
          fail_cnt++;
          test_fail++;
        end else begin
          compare("flit_o", flit_i, flits_q[0]);
          compare("last_o", flit_width_p'(last_i), flit_width_p'(flits_q.size() == 1));
        end
      end else if (flit_v_i) begin
        $display("Flit sent with no packet outstanding (test %0d)", test_id_i);
        fail_cnt++;
        test_fail++;
      end
      if (overflow_i || ovf_exp_q) begin
        compare("overflow_o", flit_width_p'(overflow_i), flit_width_p'(ovf_exp_q));
      end
      if (flit_v_i && last_i) pkt_cnt++;
      if (overflow_i) ovf_cnt++;
      // Queue state for the coming edge.
      full = (pend_q.size() >= fifo_depth_p);  // Count before any pop.
      if (flits_q.size() != 0) begin
        void'(flits_q.pop_front());
        flit_idx++;
      end
      if (flits_q.size() == 0) flit_idx = 0;
      if (pend_q.size() != 0 && flits_q.size() == 0) load_packet(pend_q.pop_front());
      ovf_exp_q = cmd_v_i && full;               // Drop shows one cycle later.
      if (cmd_v_i && !full) pend_q.push_back(cmd_i);
      if (test_end_i) begin
        $display("Test %0d %s: %0d packets, %0d overflow pulses, %0d errors", test_id_i,
                 (test_fail == 0) ? "passed" : "failed", pkt_cnt, ovf_cnt, test_fail);
        pkt_cnt   = 0;
        ovf_cnt   = 0;
        test_fail = 0;
        tests_run++;
      end
      if (run_end_i) begin
        $display("Summary: %0d tests, %0d checks passed, %0d failed",
                 tests_run, pass_cnt, fail_cnt);
      end
    end
    idle_o = (pend_q.size() == 0) && (flits_q.size() == 0) && !ovf_exp_q;
  end

  assign fail_cnt_o = fail_cnt;
  assign pass_cnt_o = pass_cnt;

endmodule

//--- sim/tb_lce_cmd_wh_tx.sv
// Testbench for the LCE command wormhole transmit endpoint.
// Applies a table of commands with gaps and lets wh_flit_checker compare.
`timescale 1ns/1ps

module tb_lce_cmd_wh_tx
  import lce_cmd_pkg::*;
();

  localparam int flit_width_lp = 32;
  localparam int fifo_depth_lp = 4;
  localparam int lce_y_cord_lp = 1;
  localparam int n_entries_lp  = 9 + 14 + 16 + 4 + fifo_depth_lp + 3;

  typedef struct packed {
    lce_cmd_msg_s cmd;
    logic [7:0]   gap;   // Cycles from this strobe to the next.
    logic [3:0]   tid;
  } stim_s;

  logic                     clk;
  logic                     rst_n;
  logic                     cmd_v;
  lce_cmd_msg_s             cmd;
  logic                     flit_v;
  logic [flit_width_lp-1:0] flit;
  logic                     last;
  logic                     overflow;
  logic [3:0]               test_id;
  logic                     test_end;
  logic                     run_end;
  logic                     idle;
  int                       fail_cnt;
  int                       pass_cnt;
  stim_s                    stim_q [n_entries_lp];
  int                       n_q = 0;
  int                       limit_ns = 0;
  logic [31:0]              lfsr_q;

  lce_cmd_wh_tx #(
    .flit_width_p(flit_width_lp),
    .fifo_depth_p(fifo_depth_lp),
    .lce_y_cord_p(lce_y_cord_lp)
  ) lce_cmd_wh_tx_i (
    .clk_i(clk), .rst_n_i(rst_n), .cmd_v_i(cmd_v), .cmd_i(cmd),
    .flit_v_o(flit_v), .flit_o(flit), .last_o(last), .overflow_o(overflow)
  );

  wh_flit_checker #(
    .flit_width_p(flit_width_lp),
    .fifo_depth_p(fifo_depth_lp),
    .lce_y_cord_p(lce_y_cord_lp)
  ) wh_flit_checker_i (
    .clk_i(clk), .rst_n_i(rst_n), .cmd_v_i(cmd_v), .cmd_i(cmd),
    .flit_v_i(flit_v), .flit_i(flit), .last_i(last), .overflow_i(overflow),
    .test_id_i(test_id), .test_end_i(test_end), .run_end_i(run_end),
    .idle_o(idle), .fail_cnt_o(fail_cnt), .pass_cnt_o(pass_cnt)
  );

  always #4 clk = ~clk;  // 8 ns period.

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic int data_bytes(lce_cmd_header_s h);
    return (h.msg_type == e_cmd_data || h.msg_type == e_cmd_uc_data) ? (1 << h.size) : 0;
  endfunction

  task automatic add_entry(lce_msg_type_e t, lce_msg_size_e s, int dst, int gap, int tid);
    lce_cmd_msg_s c;
    c                 = '0;
    c.header.msg_type = t;
    c.header.size     = s;
    c.header.dst_id   = 4'(dst);
    c.header.src_id   = 4'(rand_bits(4));
    c.header.way_id   = 3'(rand_bits(3));
    c.header.addr[33:32] = 2'(rand_bits(2));
    c.header.addr[31:0]  = rand_bits(32);
    for (int b = 0; b < data_bytes(c.header); b++) c.data[8*b +: 8] = 8'(rand_bits(8));
    stim_q[n_q] = {c, 8'(gap), 4'(tid)};
    n_q++;
    // Flits of the packet plus the gap, in ns.
    limit_ns += ((wh_hdr_width_c + 8 * data_bytes(c.header) + flit_width_lp - 1)
                 / flit_width_lp + gap) * 8;
  endtask

  task automatic build_table();
    for (int t = 0; t < 9; t++) add_entry(lce_msg_type_e'(t), e_size_1, t, 6, 1);
    for (int s = 0; s < 7; s++) add_entry(e_cmd_data, lce_msg_size_e'(s), s, 24, 2);
    for (int s = 0; s < 7; s++) add_entry(e_cmd_uc_data, lce_msg_size_e'(s), 15 - s, 24, 2);
    for (int d = 0; d < 16; d++) add_entry(e_cmd_inv, e_size_1, d, 5, 3);
    add_entry(e_cmd_st, e_size_1, 3, 1, 4);       // Back to back within depth.
    add_entry(e_cmd_data, e_size_8, 6, 1, 4);
    add_entry(e_cmd_wb, e_size_1, 9, 1, 4);
    add_entry(e_cmd_uc_data, e_size_64, 12, 1, 4);
    for (int i = 0; i < fifo_depth_lp + 3; i++) add_entry(e_cmd_data, e_size_64, i, 1, 5);
    limit_ns += 50 * 8;
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmd_v    = 1'b0;
    cmd      = '0;
    test_id  = '0;
    test_end = 1'b0;
    run_end  = 1'b0;
    lfsr_q   = 32'h846bd814;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < n_entries_lp; i++) begin
      test_id = stim_q[i].tid;
      cmd_v   = 1'b1;
      cmd     = stim_q[i].cmd;
      @(posedge clk);
      #1;
      cmd_v = 1'b0;
      repeat (int'(stim_q[i].gap) - 1) begin
        @(posedge clk);
        #1;
      end
      if (i == n_entries_lp - 1 || stim_q[i+1].tid != stim_q[i].tid) begin
        while (!idle) begin    // Drain the queue and serializer.
          @(posedge clk);
          #1;
        end
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
      end
    end
    run_end = 1'b1;
    @(posedge clk);
    #1;
    run_end = 1'b0;
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table.
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout: run still busy after %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- all.f
hdl/lce_cmd_pkg.sv
hdl/lce_cmd_ingress_fifo.sv
hdl/lce_id_to_cord.sv
hdl/lce_cmd_wh_encode.sv
hdl/wh_flit_serializer.sv
hdl/lce_cmd_wh_tx.sv
sim/wh_flit_checker.sv
sim/tb_lce_cmd_wh_tx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lce_cmd_wh_tx
RTL_TOP   ?= lce_cmd_wh_tx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
VFLAGS    ?= --timing --timescale 1ns/1ps
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# A crash without output still counts as a failure.
run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
